// ==== verilog.f ====
+incdir+.
dcache_pkg.sv
dcache_tag_store.sv
dcache_plru.sv
dcache_data_store.sv
dcache_ctrl.sv
dcache_l1.sv
dcache_tb_assertions.sv
dcache_tb.sv

// ==== Bender.yml ====
package:
  name: dcache_l1

export_include_dirs:
  - .

sources:
  - dcache_pkg.sv
  - dcache_tag_store.sv
  - dcache_plru.sv
  - dcache_data_store.sv
  - dcache_ctrl.sv
  - dcache_l1.sv
  - target: test
    files:
      - dcache_tb_assertions.sv
      - dcache_tb.sv

// ==== dcache_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dcache_consts.svh"

module dcache_tb import dcache_pkg::*; ();

    localparam int timeout_cycles = 2000;

    logic                       clk;
    logic                       rst_n;
    logic                       req_valid;
    cache_req_t                 req;
    logic                       req_ready;
    logic                       resp_valid;
    logic [`DC_XLEN-1:0]        resp_rdata;
    logic                       resp_error;
    logic                       flush_all;
    logic                       flush_done;
    logic                       mem_valid;
    mem_req_t                   mem_req;
    logic                       mem_ack;
    logic [`DC_LINE_W-1:0]      mem_rdata;
    logic                       mem_error;

    // Backing memory and the architectural view including unwritten stores
    logic [`DC_LINE_W-1:0]      mem_lines [logic [`DC_PADDR_W-1:0]];
    logic [`DC_LINE_W-1:0]      shadow    [logic [`DC_PADDR_W-1:0]];
    logic [`DC_PADDR_W-1:0]     wr_log_addr [$];
    logic [`DC_LINE_W-1:0]      wr_log_data [$];
    int                         rd_count;

    // Expected cache contents and replacement state
    logic [2:0]                 tree  [`DC_NUM_SETS];
    logic [`DC_TAG_W-1:0]       mtag  [`DC_NUM_SETS][`DC_NUM_WAYS];
    logic                       mvalid[`DC_NUM_SETS][`DC_NUM_WAYS];
    logic                       mdirty[`DC_NUM_SETS][`DC_NUM_WAYS];

    int                         errors;
    int                         checks;
    int                         tests_run;
    int                         test_start_errors;

    dcache_l1 i_dcache_l1 (
        .clk, .rst_n,
        .req_valid, .req, .req_ready,
        .resp_valid, .resp_rdata, .resp_error,
        .flush_all, .flush_done,
        .mem_valid, .mem_req, .mem_ack, .mem_rdata, .mem_error
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ====================
    // Helpers
    // ====================

    function automatic logic [`DC_PADDR_W-1:0] make_addr(input logic [`DC_TAG_W-1:0] tag,
                                                       input int set, input int word);
        return {tag, 4'(set), 3'(word), 3'b000};
    endfunction

    function automatic logic in_error_range(input logic [`DC_PADDR_W-1:0] a);
        return a[31:16] == 16'h8000;
    endfunction

    // Every word holds three times its own byte address
    function automatic logic [`DC_LINE_W-1:0] pattern_line(input logic [`DC_PADDR_W-1:0] a);
        logic [`DC_LINE_W-1:0] line;
        for (int w = 0; w < 8; w++)
            line[w*64 +: 64] = (64'(a) + 64'(w * 8)) * 64'd3;
        return line;
    endfunction

    function automatic logic [`DC_LINE_W-1:0] memory_line(input logic [`DC_PADDR_W-1:0] a);
        return mem_lines.exists(a) ? mem_lines[a] : pattern_line(a);
    endfunction

    function automatic logic [`DC_LINE_W-1:0] shadow_line(input logic [`DC_PADDR_W-1:0] a);
        return shadow.exists(a) ? shadow[a] : pattern_line(a);
    endfunction

    // Bit 0 selects the pair, bit 1 or bit 2 the way in it
    function automatic logic [1:0] tree_victim(input logic [2:0] t);
        if (t[0] == 1'b0)
            return (t[1] == 1'b1) ? 2'd0 : 2'd1;
        return (t[2] == 1'b1) ? 2'd2 : 2'd3;
    endfunction

    function automatic logic [2:0] tree_after_touch(input logic [2:0] t, input logic [1:0] way);
        logic [2:0] n;
        n = t;
        case (way)
            2'd0: n = {t[2], 1'b0, 1'b1};
            2'd1: n = {t[2], 1'b1, 1'b1};
            2'd2: n = {1'b0, t[1], 1'b0};
            default: n = {1'b1, t[1], 1'b0};
        endcase
        return n;
    endfunction

    task automatic compare(input string name, input logic [`DC_LINE_W-1:0] got,
                           input logic [`DC_LINE_W-1:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, got, expected);
        end
    endtask

    task automatic stop_on_timeout(input string what);
        $display("Timeout: %s", what);
        $display("TESTBENCH FAILED");
        $finish;
    endtask

    task automatic end_test(input string name);
        if (errors == test_start_errors)
            $display("test %0d %s: ok", tests_run + 1, name);
        else
            $display("test %0d %s: %0d errors", tests_run + 1, name, errors - test_start_errors);
        tests_run++;
        test_start_errors = errors;
    endtask

    // ====================
    // Memory model
    // ====================

    task automatic serve_memory();
        int                     delay;
        logic [`DC_PADDR_W-1:0] a;
        delay     = 0;
        mem_ack   = 1'b0;
        mem_error = 1'b0;
        mem_rdata = '0;
        forever begin
            @(posedge clk);
            #1;
            mem_ack   = 1'b0;
            mem_error = 1'b0;
            if (mem_valid) begin
                if (delay == 0)
                    delay = 1 + $urandom % 5;
                delay--;
                if (delay == 0) begin
                    a = mem_req.addr;
                    if (in_error_range(a))
                        mem_error = 1'b1;
                    else
                        mem_ack = 1'b1;
                    if (mem_req.we) begin
                        wr_log_addr.push_back(a);
                        wr_log_data.push_back(mem_req.wdata);
                        if (!in_error_range(a))
                            mem_lines[a] = mem_req.wdata;
                    end else begin
                        rd_count++;
                        mem_rdata = memory_line(a);
                    end
                end
            end
        end
    endtask

    // ====================
    // Request driver
    // ====================

    task automatic run_request(input logic we, input logic [`DC_PADDR_W-1:0] addr,
                               input logic [`DC_XLEN-1:0] wdata, input logic [7:0] wstrb,
                               output logic [`DC_XLEN-1:0] rdata, output logic err,
                               output int lat);
        int t;
        req_valid     = 1'b1;
        req.addr.flat = addr;
        req.wdata     = wdata;
        req.wstrb     = wstrb;
        req.we        = we;
        t = 0;
        @(negedge clk);
        while (!req_ready) begin
            t++;
            if (t > timeout_cycles)
                stop_on_timeout("request was never accepted");
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        req_valid = 1'b0;
        lat = 0;
        do begin
            @(negedge clk);
            lat++;
            if (lat > timeout_cycles)
                stop_on_timeout("no response to an accepted request");
        end while (!resp_valid);
        rdata = resp_rdata;
        err   = resp_error;
        @(posedge clk);
        #1;
    endtask

    // One load or store, checked against the expected cache and memory state
    task automatic access(input logic we, input logic [`DC_PADDR_W-1:0] addr,
                          input logic [`DC_XLEN-1:0] wdata, input logic [7:0] wstrb);
        logic [`DC_PADDR_W-1:0] line_addr;
        logic [`DC_PADDR_W-1:0] wb_addr;
        logic [`DC_INDEX_W-1:0] set;
        logic [`DC_TAG_W-1:0]   tag;
        logic [1:0]             way;
        logic                   hit;
        logic                   wb;
        logic                   bad;
        logic [`DC_LINE_W-1:0]  line;
        logic [`DC_XLEN-1:0]    rdata;
        logic                   err;
        int                     lat;
        int                     ws;
        line_addr = {addr[31:6], 6'b0};
        set       = addr[9:6];
        tag       = addr[31:10];
        ws        = addr[5:3];
        bad       = in_error_range(addr);
        hit       = 1'b0;
        way       = tree_victim(tree[set]);
        for (int w = 0; w < `DC_NUM_WAYS; w++) begin
            if (mvalid[set][w] && mtag[set][w] == tag) begin
                hit = 1'b1;
                way = 2'(w);
            end
        end
        wb      = !hit && mvalid[set][way] && mdirty[set][way];
        wb_addr = {mtag[set][way], set, 6'b0};
        line    = shadow_line(line_addr);
        wr_log_addr.delete();
        wr_log_data.delete();
        rd_count = 0;
        run_request(we, addr, wdata, wstrb, rdata, err, lat);
        compare("resp_error", err, bad);
        compare("mem read count", rd_count, hit ? 0 : 1);
        compare("mem write count", wr_log_addr.size(), wb ? 1 : 0);
        if (wb && wr_log_addr.size() == 1) begin
            compare("write-back addr", wr_log_addr[0], wb_addr);
            compare("write-back data", wr_log_data[0], shadow_line(wb_addr));
        end
        if (hit)
            compare("hit latency", lat, 2);
        if (!bad) begin
            // Loads return the word, stores the old word
            compare("resp_rdata", rdata, line[ws*64 +: 64]);
            if (we) begin
                for (int b = 0; b < 8; b++) begin
                    if (wstrb[b])
                        line[ws*64 + b*8 +: 8] = wdata[b*8 +: 8];
                end
                shadow[line_addr] = line;
            end
            if (hit) begin
                mdirty[set][way] = mdirty[set][way] | we;
            end else begin
                mtag[set][way]   = tag;
                mvalid[set][way] = 1'b1;
                mdirty[set][way] = we;
            end
            tree[set] = tree_after_touch(tree[set], way);
        end
    endtask

    // ====================
    // Tests
    // ====================

    task automatic test_load_miss_hit();
        logic [`DC_PADDR_W-1:0] a;
        a = make_addr(22'h100, 3, 2);
        access(1'b0, a, '0, '0);
        access(1'b0, a, '0, '0);
        end_test("load miss then hit");
    endtask

    task automatic test_store_merge();
        logic [`DC_PADDR_W-1:0] a;
        a = make_addr(22'h100, 3, 3);
        access(1'b1, a, {$urandom, $urandom}, 8'($urandom));
        access(1'b0, a, '0, '0);
        end_test("store byte merge");
    endtask

    task automatic test_plru_evict();
        for (int i = 0; i < 5; i++)
            access(1'b1, make_addr(22'h200 + i, 5, i), {$urandom, $urandom}, 8'hff);
        for (int i = 0; i < 5; i++)
            access(1'b0, make_addr(22'h200 + i, 5, i), '0, '0);
        end_test("pseudo-LRU eviction");
    endtask

    task automatic test_flush();
        logic [`DC_PADDR_W-1:0] exp_addr [$];
        int                     t;
        for (int s = 0; s < `DC_NUM_SETS; s++) begin
            for (int w = 0; w < `DC_NUM_WAYS; w++) begin
                if (mvalid[s][w] && mdirty[s][w])
                    exp_addr.push_back({mtag[s][w], 4'(s), 6'b0});
            end
        end
        wr_log_addr.delete();
        wr_log_data.delete();
        rd_count  = 0;
        flush_all = 1'b1;
        t = 0;
        @(negedge clk);
        while (!flush_done) begin
            t++;
            if (t > timeout_cycles)
                stop_on_timeout("flush_done never pulsed");
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        flush_all = 1'b0;
        compare("flush write count", wr_log_addr.size(), exp_addr.size());
        compare("flush read count", rd_count, 0);
        for (int i = 0; i < exp_addr.size() && i < wr_log_addr.size(); i++) begin
            compare("flush addr", wr_log_addr[i], exp_addr[i]);
            compare("flush data", wr_log_data[i], shadow_line(exp_addr[i]));
        end
        for (int s = 0; s < `DC_NUM_SETS; s++) begin
            for (int w = 0; w < `DC_NUM_WAYS; w++)
                mdirty[s][w] = 1'b0;
        end
        // Lines stay valid, so every one of them must still hit
        for (int s = 0; s < `DC_NUM_SETS; s++) begin
            for (int w = 0; w < `DC_NUM_WAYS; w++) begin
                if (mvalid[s][w])
                    access(1'b0, {mtag[s][w], 4'(s), 6'b0}, '0, '0);
            end
        end
        end_test("flush all");
    endtask

    task automatic test_mem_error();
        access(1'b0, 32'h8000_0000 | make_addr(22'h0, 9, 0), '0, '0);
        access(1'b0, make_addr(22'h300, 9, 1), '0, '0);
        end_test("memory error");
    endtask

    // ====================
    // Main sequence
    // ====================

    initial begin
        void'($urandom(19569));
        rst_n             = 1'b0;
        req_valid         = 1'b0;
        req               = '0;
        flush_all         = 1'b0;
        errors            = 0;
        checks            = 0;
        tests_run         = 0;
        test_start_errors = 0;
        rd_count          = 0;
        for (int s = 0; s < `DC_NUM_SETS; s++) begin
            tree[s] = 3'b000;
            for (int w = 0; w < `DC_NUM_WAYS; w++) begin
                mtag[s][w]   = '0;
                mvalid[s][w] = 1'b0;
                mdirty[s][w] = 1'b0;
            end
        end
        fork
            serve_memory();
        join_none
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;

        test_load_miss_hit();
        test_store_merge();
        test_plru_evict();
        test_flush();
        test_mem_error();

        errors = errors + i_dcache_l1.i_assertions.failures;
        $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== dcache_tb_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module dcache_tb_assertions import dcache_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        req_ready,
    input  logic        resp_valid,
    input  logic        mem_valid,
    input  mem_req_t    mem_req,
    input  logic        mem_ack,
    input  logic        mem_error,
    input  dc_state_t   state
);

    int failures = 0;

    // Memory request held unchanged until acknowledge or error
    mem_req_held: assert property (@(posedge clk) disable iff (!rst_n)
        mem_valid && !mem_ack && !mem_error |=> mem_valid && $stable(mem_req))
        else begin
            failures++;
            $error("mem_req changed while mem_valid was held");
        end

    resp_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid |=> !resp_valid)
        else begin
            failures++;
            $error("resp_valid high for two cycles");
        end

    ready_only_idle: assert property (@(posedge clk) disable iff (!rst_n)
        state != S_IDLE |-> !req_ready)
        else begin
            failures++;
            $error("req_ready high outside S_IDLE");
        end

endmodule

bind dcache_l1 dcache_tb_assertions i_assertions (
    .clk, .rst_n, .req_ready, .resp_valid,
    .mem_valid, .mem_req, .mem_ack, .mem_error,
    .state (i_ctrl.state_q)
);

`default_nettype wire

// ==== dcache_l1.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dcache_consts.svh"

module dcache_l1 import dcache_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    req_valid,
    input  cache_req_t              req,
    output logic                    req_ready,
    output logic                    resp_valid,
    output logic [`DC_XLEN-1:0]     resp_rdata,
    output logic                    resp_error,
    input  logic                    flush_all,
    output logic                    flush_done,
    output logic                    mem_valid,
    output mem_req_t                mem_req,
    input  logic                    mem_ack,
    input  logic [`DC_LINE_W-1:0]   mem_rdata,
    input  logic                    mem_error
);

    cache_req_t                 req_q;
    tag_entry_t                 tag_wentry;
    tag_entry_t                 victim_entry;
    tag_entry_t                 flush_entry;
    logic [`DC_INDEX_W-1:0]     cur_index;
    logic [`DC_INDEX_W-1:0]     flush_index;
    logic [`DC_WAY_W-1:0]       cur_way;
    logic [`DC_WAY_W-1:0]       flush_way;
    logic [`DC_WAY_W-1:0]       hit_way;
    logic [`DC_WAY_W-1:0]       victim_way;
    logic                       tag_we;
    logic                       hit;
    logic                       plru_touch;
    logic                       fill_en;
    logic                       store_en;
    logic [`DC_LINE_W-1:0]      fill_line;
    logic [`DC_LINE_W-1:0]      rd_line;
    logic [`DC_XLEN-1:0]        rd_word;

    dcache_ctrl i_ctrl (
        .clk, .rst_n,
        .req_valid, .req, .req_ready,
        .resp_valid, .resp_rdata, .resp_error,
        .flush_all, .flush_done,
        .mem_valid, .mem_req, .mem_ack, .mem_rdata, .mem_error,
        .cur_index, .cur_way, .tag_we, .tag_wentry, .flush_index, .flush_way,
        .hit, .hit_way, .victim_entry, .flush_entry,
        .plru_touch, .victim_way,
        .req_q, .fill_en, .store_en, .fill_line, .rd_word, .rd_line
    );

    dcache_tag_store i_tag_store (
        .clk, .rst_n,
        .rd_index    (cur_index),
        .flush_index, .flush_way,
        .cmp_tag     (req_q.addr.f.tag),
        .wr_en       (tag_we),
        .wr_way      (cur_way),
        .wr_entry    (tag_wentry),
        .victim_way, .hit, .hit_way, .victim_entry, .flush_entry
    );

    dcache_plru i_plru (
        .clk, .rst_n,
        .index     (req_q.addr.f.index),
        .touch     (plru_touch),
        .touch_way (cur_way),
        .victim_way
    );

    // Writes always target the request's set, reads follow the scan
    dcache_data_store i_data_store (
        .clk,
        .index     (req_q.addr.f.index),
        .way       (cur_way),
        .word_sel  (req_q.addr.f.word_sel),
        .wstrb     (req_q.wstrb),
        .wdata     (req_q.wdata),
        .fill_line, .fill_en, .store_en,
        .rd_index  (cur_index),
        .rd_way    (cur_way),
        .rd_word, .rd_line
    );

endmodule

`default_nettype wire

// ==== dcache_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dcache_consts.svh"

module dcache_ctrl import dcache_pkg::*; (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        req_valid,
    input  cache_req_t                  req,
    output logic                        req_ready,
    output logic                        resp_valid,
    output logic [`DC_XLEN-1:0]         resp_rdata,
    output logic                        resp_error,
    input  logic                        flush_all,
    output logic                        flush_done,
    output logic                        mem_valid,
    output mem_req_t                    mem_req,
    input  logic                        mem_ack,
    input  logic [`DC_LINE_W-1:0]       mem_rdata,
    input  logic                        mem_error,
    // Tag store
    output logic [`DC_INDEX_W-1:0]      cur_index,
    output logic [`DC_WAY_W-1:0]        cur_way,
    output logic                        tag_we,
    output tag_entry_t                  tag_wentry,
    output logic [`DC_INDEX_W-1:0]      flush_index,
    output logic [`DC_WAY_W-1:0]        flush_way,
    input  logic                        hit,
    input  logic [`DC_WAY_W-1:0]        hit_way,
    input  tag_entry_t                  victim_entry,
    input  tag_entry_t                  flush_entry,
    // Pseudo-LRU
    output logic                        plru_touch,
    input  logic [`DC_WAY_W-1:0]        victim_way,
    // Data store
    output cache_req_t                  req_q,
    output logic                        fill_en,
    output logic                        store_en,
    output logic [`DC_LINE_W-1:0]       fill_line,
    input  logic [`DC_XLEN-1:0]         rd_word,
    input  logic [`DC_LINE_W-1:0]       rd_line
);

    dc_state_t state_q;
    dc_state_t state_d;

    logic [`DC_WAY_W-1:0]               way_q;
    logic [`DC_TAG_W-1:0]               victim_tag_q;
    logic [`DC_INDEX_W+`DC_WAY_W-1:0]   flush_ptr_q;
    logic                               flush_done_q;
    logic                               flushing;
    logic                               flush_last;
    logic                               answer;
    logic                               mem_fail;
    paddr_u                             line_addr;

    // Scan pointer runs set-major, way in the low bits
    assign flush_index = flush_ptr_q[`DC_INDEX_W+`DC_WAY_W-1:`DC_WAY_W];
    assign flush_way   = flush_ptr_q[`DC_WAY_W-1:0];
    assign flush_last  = &flush_ptr_q;
    assign flushing    = (state_q == S_FLUSH_SCAN) || (state_q == S_FLUSH_WB);

    assign cur_index = flushing ? flush_index : req_q.addr.f.index;
    assign cur_way   = flushing ? flush_way : way_q;

    // ====================
    // Next state
    // ====================

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: begin
                if (flush_all && !flush_done_q)
                    state_d = S_FLUSH_SCAN;
                else if (req_valid && req_ready)
                    state_d = S_TAG_CHECK;
            end
            S_TAG_CHECK: begin
                if (hit)
                    state_d = S_HIT;
                else if (victim_entry.valid && victim_entry.dirty)
                    state_d = S_WB;
                else
                    state_d = S_REFILL;
            end
            S_WB: begin
                if (mem_error)
                    state_d = S_IDLE;
                else if (mem_ack)
                    state_d = S_REFILL;
            end
            S_REFILL: begin
                if (mem_error)
                    state_d = S_IDLE;
                else if (mem_ack)
                    state_d = S_INSTALL;
            end
            S_FLUSH_SCAN: begin
                if (flush_entry.valid && flush_entry.dirty)
                    state_d = S_FLUSH_WB;
                else if (flush_last)
                    state_d = S_IDLE;
            end
            S_FLUSH_WB: begin
                if (mem_ack || mem_error)
                    state_d = flush_last ? S_IDLE : S_FLUSH_SCAN;
            end
            default: state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q      <= S_IDLE;
            flush_ptr_q  <= '0;
            flush_done_q <= 1'b0;
        end else begin
            state_q      <= state_d;
            flush_done_q <= flushing && (state_d == S_IDLE);
            if (state_q == S_IDLE)
                flush_ptr_q <= '0;
            else if (flushing && (state_d == S_FLUSH_SCAN))
                flush_ptr_q <= flush_ptr_q + 1'b1;
        end
    end

    // Request, victim and refill payload
    always_ff @(posedge clk) begin
        if (req_valid && req_ready)
            req_q <= req;
        if (state_q == S_TAG_CHECK) begin
            way_q        <= hit ? hit_way : victim_way;
            victim_tag_q <= victim_entry.tag;
        end
        if ((state_q == S_REFILL) && mem_ack)
            fill_line <= mem_rdata;
    end

    // ====================
    // Array updates
    // ====================

    assign fill_en    = (state_q == S_INSTALL);
    assign store_en   = ((state_q == S_HIT) || fill_en) && req_q.we;
    assign plru_touch = (state_q == S_HIT) || fill_en;

    always_comb begin
        tag_we           = 1'b0;
        tag_wentry.valid = 1'b1;
        tag_wentry.dirty = req_q.we;
        tag_wentry.tag   = req_q.addr.f.tag;
        case (state_q)
            S_HIT:     tag_we = req_q.we;
            S_INSTALL: tag_we = 1'b1;
            S_FLUSH_WB: begin
                // Line stays valid, now clean
                tag_we           = mem_ack;
                tag_wentry.dirty = 1'b0;
                tag_wentry.tag   = flush_entry.tag;
            end
            default: ;
        endcase
    end

    // ====================
    // Memory port
    // ====================

    always_comb begin
        line_addr.flat = '0;
        mem_req        = '0;
        mem_valid      = 1'b0;
        case (state_q)
            S_WB: begin
                mem_valid         = 1'b1;
                mem_req.we        = 1'b1;
                mem_req.wdata     = rd_line;
                line_addr.f.tag   = victim_tag_q;
                line_addr.f.index = req_q.addr.f.index;
            end
            S_REFILL: begin
                mem_valid         = 1'b1;
                line_addr.f.tag   = req_q.addr.f.tag;
                line_addr.f.index = req_q.addr.f.index;
            end
            S_FLUSH_WB: begin
                mem_valid         = 1'b1;
                mem_req.we        = 1'b1;
                mem_req.wdata     = rd_line;
                line_addr.f.tag   = flush_entry.tag;
                line_addr.f.index = flush_index;
            end
            default: ;
        endcase
        mem_req.addr = line_addr.flat;
    end

    // ====================
    // Load/store side
    // ====================

    assign req_ready  = (state_q == S_IDLE) && !flush_all;
    assign flush_done = flush_done_q;

    assign answer     = (state_q == S_HIT) || (state_q == S_INSTALL);
    assign mem_fail   = mem_error && ((state_q == S_WB) || (state_q == S_REFILL));
    assign resp_valid = answer || mem_fail;
    assign resp_error = mem_fail;
    assign resp_rdata = answer ? rd_word : '0;

endmodule

`default_nettype wire

// ==== dcache_data_store.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dcache_consts.svh"

module dcache_data_store (
    input  logic                        clk,
    input  logic [`DC_INDEX_W-1:0]      index,
    input  logic [`DC_WAY_W-1:0]        way,
    input  logic [`DC_WORD_SEL_W-1:0]   word_sel,
    input  logic [`DC_STRB_W-1:0]       wstrb,
    input  logic [`DC_XLEN-1:0]         wdata,
    input  logic [`DC_LINE_W-1:0]       fill_line,
    input  logic                        fill_en,
    input  logic                        store_en,
    input  logic [`DC_INDEX_W-1:0]      rd_index,
    input  logic [`DC_WAY_W-1:0]        rd_way,
    output logic [`DC_XLEN-1:0]         rd_word,
    output logic [`DC_LINE_W-1:0]       rd_line
);

    logic [`DC_LINE_W-1:0] lines [`DC_NUM_SETS][`DC_NUM_WAYS];
    logic [`DC_LINE_W-1:0] base_line;
    logic [`DC_LINE_W-1:0] merged_line;

    // Raw line for write-backs
    assign rd_line = lines[rd_index][rd_way];

    // A refill takes the incoming line in place of the stored one
    assign base_line = fill_en ? fill_line : rd_line;

    // Word before any store merge, so a store returns the old value
    assign rd_word = base_line[word_sel*`DC_XLEN +: `DC_XLEN];

    // ====================
    // Byte strobe merge
    // ====================

    always_comb begin
        merged_line = base_line;
        if (store_en) begin
            for (int b = 0; b < `DC_STRB_W; b++) begin
                if (wstrb[b])
                    merged_line[word_sel*`DC_XLEN + b*8 +: 8] = wdata[b*8 +: 8];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill_en || store_en)
            lines[index][way] <= merged_line;
    end

endmodule

`default_nettype wire

// ==== dcache_plru.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dcache_consts.svh"

module dcache_plru (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [`DC_INDEX_W-1:0]  index,
    input  logic                    touch,
    input  logic [`DC_WAY_W-1:0]    touch_way,
    output logic [`DC_WAY_W-1:0]    victim_way
);

    // Bit 0 picks the pair, bit 1 and bit 2 pick within a pair
    logic [2:0] tree_q [`DC_NUM_SETS];
    logic [2:0] cur_tree;
    logic [2:0] next_tree;

    assign cur_tree = tree_q[index];

    always_comb begin
        if (!cur_tree[0])
            victim_way = cur_tree[1] ? 2'd0 : 2'd1;
        else
            victim_way = cur_tree[2] ? 2'd2 : 2'd3;
    end

    // Point every node on the path away from the touched way
    always_comb begin
        next_tree = cur_tree;
        if (touch_way[1]) begin
            next_tree[0] = 1'b0;
            next_tree[2] = touch_way[0];
        end else begin
            next_tree[0] = 1'b1;
            next_tree[1] = touch_way[0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < `DC_NUM_SETS; s++)
                tree_q[s] <= '0;
        end else if (touch) begin
            tree_q[index] <= next_tree;
        end
    end

endmodule

`default_nettype wire

// ==== dcache_tag_store.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dcache_consts.svh"

module dcache_tag_store import dcache_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [`DC_INDEX_W-1:0]  rd_index,
    input  logic [`DC_INDEX_W-1:0]  flush_index,
    input  logic [`DC_WAY_W-1:0]    flush_way,
    input  logic [`DC_TAG_W-1:0]    cmp_tag,
    input  logic                    wr_en,
    input  logic [`DC_WAY_W-1:0]    wr_way,
    input  tag_entry_t              wr_entry,
    input  logic [`DC_WAY_W-1:0]    victim_way,
    output logic                    hit,
    output logic [`DC_WAY_W-1:0]    hit_way,
    output tag_entry_t              victim_entry,
    output tag_entry_t              flush_entry
);

    // State bits per set, one bit per way
    logic [`DC_NUM_WAYS-1:0] valid_q [`DC_NUM_SETS];
    logic [`DC_NUM_WAYS-1:0] dirty_q [`DC_NUM_SETS];
    logic [`DC_TAG_W-1:0]    tag_q   [`DC_NUM_SETS][`DC_NUM_WAYS];

    function automatic tag_entry_t entry_at(
        input logic [`DC_INDEX_W-1:0] set,
        input logic [`DC_WAY_W-1:0]   way
    );
        tag_entry_t e;
        e.valid = valid_q[set][way];
        e.dirty = dirty_q[set][way];
        e.tag   = tag_q[set][way];
        return e;
    endfunction

    // ====================
    // Parallel tag compare
    // ====================

    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < `DC_NUM_WAYS; w++) begin
            if (valid_q[rd_index][w] && (tag_q[rd_index][w] == cmp_tag)) begin
                hit     = 1'b1;
                hit_way = w[`DC_WAY_W-1:0];
            end
        end
    end

    assign victim_entry = entry_at(rd_index, victim_way);
    assign flush_entry  = entry_at(flush_index, flush_way);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < `DC_NUM_SETS; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
        end else if (wr_en) begin
            valid_q[rd_index][wr_way] <= wr_entry.valid;
            dirty_q[rd_index][wr_way] <= wr_entry.dirty;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en)
            tag_q[rd_index][wr_way] <= wr_entry.tag;
    end

endmodule

`default_nettype wire

// ==== dcache_pkg.sv ====
`default_nettype none

`include "dcache_consts.svh"

package dcache_pkg;

    // Physical address as seen by the cache
    typedef struct packed {
        logic [`DC_TAG_W-1:0]                   tag;
        logic [`DC_INDEX_W-1:0]                 index;
        logic [`DC_WORD_SEL_W-1:0]              word_sel;
        logic [`DC_OFFSET_W-`DC_WORD_SEL_W-1:0] byte_off;
    } paddr_fields_t;

    // Flat on the memory side, split inside the cache
    typedef union packed {
        logic [`DC_PADDR_W-1:0] flat;
        paddr_fields_t          f;
    } paddr_u;

    typedef struct packed {
        paddr_u                 addr;
        logic [`DC_XLEN-1:0]    wdata;
        logic [`DC_STRB_W-1:0]  wstrb;
        logic                   we;
    } cache_req_t;

    // Line-granular memory request
    typedef struct packed {
        logic                   we;
        logic [`DC_PADDR_W-1:0] addr;
        logic [`DC_LINE_W-1:0]  wdata;
    } mem_req_t;

    typedef struct packed {
        logic                   valid;
        logic                   dirty;
        logic [`DC_TAG_W-1:0]   tag;
    } tag_entry_t;

    typedef enum logic [2:0] {
        S_IDLE,
        S_TAG_CHECK,
        S_HIT,
        S_WB,
        S_REFILL,
        S_INSTALL,
        S_FLUSH_SCAN,
        S_FLUSH_WB
    } dc_state_t;

endpackage

`default_nettype wire

// ==== dcache_consts.svh ====
`ifndef DCACHE_CONSTS_SVH
`define DCACHE_CONSTS_SVH

// ====================
// Address and data widths
// ====================

`define DC_PADDR_W      32
`define DC_XLEN         64
`define DC_LINE_BYTES   64
`define DC_LINE_W       (`DC_LINE_BYTES * 8)

// ====================
// Cache geometry
// ====================

// 4 ways x 16 sets x 64 bytes
`define DC_NUM_WAYS     4
`define DC_NUM_SETS     16
`define DC_OFFSET_W     6
`define DC_INDEX_W      4
`define DC_TAG_W        22
`define DC_WAY_W        2
`define DC_WORD_SEL_W   3
`define DC_STRB_W       (`DC_XLEN / 8)

`endif
